/* cmd_pkg.sv */
`default_nettype none

package cmd_pkg;

    // ********************
    // widths
    // ********************

    typedef logic [7:0]   byte_t;         // one received character
    typedef logic [3:0]   nibble_t;       // decoded hex digit
    typedef logic [127:0] operand_t;      // both operands, msd first
    typedef logic [4:0]   digit_count_t;  // digits within one operand
    typedef logic [2:0]   kw_index_t;     // position within a keyword

    // ********************
    // command codes
    // ********************

    typedef enum logic [2:0]
    {
        CMD_ON    = 3'b000,
        CMD_ADD   = 3'b001,
        CMD_MUL   = 3'b010,
        CMD_OFF   = 3'b011,
        CMD_LED   = 3'b100,
        CMD_ERROR = 3'b101,
        CMD_WR    = 3'b111
    } cmd_code_t;

    typedef struct packed
    {
        cmd_code_t code;
        operand_t  data;
    } cmd_frame_t;

    // ********************
    // characters
    // ********************

    localparam byte_t CHAR_SPACE = 8'h20;
    localparam byte_t CHAR_CR    = 8'h0D;
    localparam byte_t CHAR_LF    = 8'h0A;

    // ********************
    // keyword table
    // ********************

    localparam int NUM_KEYWORDS = 6;
    localparam int KW_MAX_LEN   = 7;

    localparam byte_t KW_TEXT [NUM_KEYWORDS][KW_MAX_LEN] = '{
        '{"A", "D", "D", "3", "6", 8'h00, 8'h00},
        '{"M", "U", "L", "6", "4", 8'h00, 8'h00},
        '{"W", "R", "4", "0", "_", "8", 8'h00},
        '{"O", "N", "4", "0", "_", "8", 8'h00},
        '{"O", "F", "F", "4", "0", "_", "8"},
        '{"L", "E", "D", "4", "0", "_", "8"}
    };

    localparam kw_index_t KW_LEN [NUM_KEYWORDS] = '{
        3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7
    };

    localparam cmd_code_t KW_CODE [NUM_KEYWORDS] = '{
        CMD_ADD, CMD_MUL, CMD_WR, CMD_ON, CMD_OFF, CMD_LED
    };

    // ********************
    // operand lengths, indexed by command code
    // ********************

    // ON ADD MUL OFF LED ERROR (unused) WR
    localparam digit_count_t OP1_DIGITS [8] = '{
        5'd10, 5'd9, 5'd16, 5'd10, 5'd10, 5'd0, 5'd0, 5'd10
    };

    localparam digit_count_t OP2_DIGITS [8] = '{
        5'd2, 5'd9, 5'd16, 5'd2, 5'd2, 5'd0, 5'd0, 5'd2
    };

endpackage

`default_nettype wire

/* keyword_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

module keyword_matcher
(
    input  logic              CLK,
    input  logic              RST,
    input  logic              kw_start,
    input  logic              kw_byte_valid,
    input  cmd_pkg::byte_t    kw_byte,
    output logic              kw_hit,
    output logic              kw_miss,
    output cmd_pkg::cmd_code_t kw_code
);

    logic [cmd_pkg::NUM_KEYWORDS-1:0] mask_q;    // keywords still in the race
    logic [cmd_pkg::NUM_KEYWORDS-1:0] mask_eff;
    logic [cmd_pkg::NUM_KEYWORDS-1:0] mask_next;
    logic [cmd_pkg::NUM_KEYWORDS-1:0] end_mask;  // survivors ending here
    cmd_pkg::kw_index_t               pos_q;
    cmd_pkg::kw_index_t               pos_eff;
    logic                             is_space;

    // ********************
    // verdict on the current byte
    // ********************

    always_comb
    begin
        mask_eff  = kw_start ? '1 : mask_q;     // first byte of a line restarts
        pos_eff   = kw_start ? '0 : pos_q;
        is_space  = (kw_byte == cmd_pkg::CHAR_SPACE);
        mask_next = '0;
        end_mask  = '0;
        kw_code   = cmd_pkg::CMD_ERROR;

        for (int k = 0; k < cmd_pkg::NUM_KEYWORDS; k++)
        begin
            if (mask_eff[k])
            begin
                if (cmd_pkg::KW_LEN[k] == pos_eff)
                begin
                    end_mask[k] = 1'b1;
                end
                else if (pos_eff < cmd_pkg::KW_LEN[k])
                begin
                    if (cmd_pkg::KW_TEXT[k][pos_eff] == kw_byte)
                    begin
                        mask_next[k] = 1'b1;
                    end
                end
            end
            if (end_mask[k])
            begin
                kw_code = cmd_pkg::KW_CODE[k];
            end
        end

        kw_hit  = is_space && $onehot(end_mask);
        kw_miss = is_space ? !kw_hit : (mask_next == '0);
    end

    // ********************
    // position and mask
    // ********************

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            mask_q <= '0;
            pos_q  <= '0;
        end
        else if (kw_byte_valid)
        begin
            mask_q <= mask_next;
            pos_q  <= pos_eff + 1'b1;   // wraps only once the word is decided
        end
    end

endmodule

`default_nettype wire

/* operand_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_collector
(
    input  logic               CLK,
    input  logic               RST,
    input  logic               op_clear,
    input  logic               op_digit_valid,
    input  logic               op_second,
    input  cmd_pkg::byte_t     op_byte,
    input  cmd_pkg::cmd_code_t op_code,
    output logic               op_last,
    output logic               op_bad,
    output cmd_pkg::operand_t  op_data
);

    cmd_pkg::nibble_t      nibble;
    cmd_pkg::digit_count_t count_q;     // digits taken in this operand
    cmd_pkg::digit_count_t required;
    logic                  hex_ok;

    // ********************
    // hex decode
    // ********************

    always_comb
    begin
        hex_ok = 1'b0;
        nibble = '0;
        if ((op_byte >= 8'h30) && (op_byte <= 8'h39))       // 0..9
        begin
            hex_ok = 1'b1;
            nibble = op_byte[3:0];
        end
        else if ((op_byte >= 8'h41) && (op_byte <= 8'h46))  // A..F, upper case only
        begin
            hex_ok = 1'b1;
            nibble = op_byte[3:0] + 4'd9;
        end
    end

    // length depends on command and on which operand is running
    assign required = op_second ? cmd_pkg::OP2_DIGITS[op_code]
                                : cmd_pkg::OP1_DIGITS[op_code];

    assign op_bad  = !hex_ok;
    assign op_last = hex_ok && ((count_q + 5'd1) == required);

    // ********************
    // shift register and digit count
    // ********************

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            op_data <= '0;
            count_q <= '0;
        end
        else if (op_clear)
        begin
            op_data <= '0;      // new line, drop earlier digits
            count_q <= '0;
        end
        else if (op_digit_valid && hex_ok)
        begin
            op_data <= {op_data[$bits(cmd_pkg::operand_t)-5:0], nibble};
            if (op_last)
            begin
                count_q <= '0;  // next operand starts fresh
            end
            else
            begin
                count_q <= count_q + 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* cmd_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer
(
    input  logic                CLK,
    input  logic                RST,
    input  logic                rx_valid,
    input  cmd_pkg::byte_t      rx_byte,
    input  logic                cmd_ack,

    output logic                kw_start,
    output logic                kw_byte_valid,
    input  logic                kw_hit,
    input  logic                kw_miss,
    input  cmd_pkg::cmd_code_t  kw_code,

    output logic                op_clear,
    output logic                op_digit_valid,
    output logic                op_second,
    output cmd_pkg::cmd_code_t  op_code,
    input  logic                op_last,
    input  logic                op_bad,
    input  cmd_pkg::operand_t   op_data,

    output logic                cmd_valid,
    output cmd_pkg::cmd_frame_t cmd
);

    typedef enum logic [2:0]
    {
        IDLE,
        KEYWORD,
        OPERAND,
        SEPARATOR,
        LINE_END,
        HOLD
    } state_t;

    state_t             state;
    cmd_pkg::cmd_code_t code_q;
    logic               second_q;   // second operand in progress
    logic               sep_ok;
    logic               fail;

    // ********************
    // routing of the byte strobe
    // ********************

    assign kw_start       = rx_valid && (state == IDLE);
    assign kw_byte_valid  = rx_valid && ((state == IDLE) || (state == KEYWORD));
    assign op_clear       = kw_start;
    assign op_digit_valid = rx_valid && (state == OPERAND);
    assign op_second      = second_q;
    assign op_code        = code_q;

    // space between operands, CR after the second one
    assign sep_ok = second_q ? (rx_byte == cmd_pkg::CHAR_CR)
                             : (rx_byte == cmd_pkg::CHAR_SPACE);

    always_comb
    begin
        fail = 1'b0;
        if (rx_valid)
        begin
            case (state)
                IDLE, KEYWORD: fail = kw_miss;
                OPERAND:       fail = op_bad;
                SEPARATOR:     fail = !sep_ok;
                default:       fail = 1'b0;
            endcase
        end
    end

    // ********************
    // line state machine
    // ********************

    always_ff @(posedge CLK or posedge RST)
    begin
        if (RST)
        begin
            state     <= IDLE;
            code_q    <= cmd_pkg::CMD_ON;
            second_q  <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else if (fail)
        begin
            code_q    <= cmd_pkg::CMD_ERROR;    // frame goes out at once
            cmd_valid <= 1'b1;
            state     <= HOLD;
        end
        else
        begin
            case (state)
                IDLE:
                    if (rx_valid)
                    begin
                        state <= KEYWORD;
                    end
                KEYWORD:
                    if (rx_valid && kw_hit)
                    begin
                        code_q   <= kw_code;
                        second_q <= 1'b0;
                        state    <= OPERAND;
                    end
                OPERAND:
                    if (rx_valid && op_last)
                    begin
                        state <= SEPARATOR;
                    end
                SEPARATOR:
                    if (rx_valid)
                    begin
                        if (second_q)
                        begin
                            state <= LINE_END;
                        end
                        else
                        begin
                            second_q <= 1'b1;
                            state    <= OPERAND;
                        end
                    end
                LINE_END:
                    if (rx_valid)
                    begin
                        cmd_valid <= 1'b1;
                        if (rx_byte != cmd_pkg::CHAR_LF)
                        begin
                            code_q <= cmd_pkg::CMD_ERROR;
                        end
                        state <= HOLD;
                    end
                HOLD:
                    if (cmd_ack)        // bytes are dropped until then
                    begin
                        cmd_valid <= 1'b0;
                        state     <= IDLE;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign cmd = '{code: code_q, data: op_data};

endmodule

`default_nettype wire

/* cmd_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_analyzer
(
    input  logic                CLK,
    input  logic                RST,
    input  logic                rx_valid,
    input  cmd_pkg::byte_t      rx_byte,
    input  logic                cmd_ack,
    output logic                cmd_valid,
    output cmd_pkg::cmd_frame_t cmd
);

    logic               kw_start;
    logic               kw_byte_valid;
    logic               kw_hit;
    logic               kw_miss;
    cmd_pkg::cmd_code_t kw_code;

    logic               op_clear;
    logic               op_digit_valid;
    logic               op_second;
    cmd_pkg::cmd_code_t op_code;
    logic               op_last;
    logic               op_bad;
    cmd_pkg::operand_t  op_data;

    cmd_sequencer u_sequencer
    (
        .CLK            (CLK),
        .RST            (RST),
        .rx_valid       (rx_valid),
        .rx_byte        (rx_byte),
        .cmd_ack        (cmd_ack),
        .kw_start       (kw_start),
        .kw_byte_valid  (kw_byte_valid),
        .kw_hit         (kw_hit),
        .kw_miss        (kw_miss),
        .kw_code        (kw_code),
        .op_clear       (op_clear),
        .op_digit_valid (op_digit_valid),
        .op_second      (op_second),
        .op_code        (op_code),
        .op_last        (op_last),
        .op_bad         (op_bad),
        .op_data        (op_data),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd)
    );

    keyword_matcher u_matcher
    (
        .CLK           (CLK),
        .RST           (RST),
        .kw_start      (kw_start),
        .kw_byte_valid (kw_byte_valid),
        .kw_byte       (rx_byte),       // same byte, strobed per state
        .kw_hit        (kw_hit),
        .kw_miss       (kw_miss),
        .kw_code       (kw_code)
    );

    operand_collector u_collector
    (
        .CLK            (CLK),
        .RST            (RST),
        .op_clear       (op_clear),
        .op_digit_valid (op_digit_valid),
        .op_second      (op_second),
        .op_byte        (rx_byte),
        .op_code        (op_code),
        .op_last        (op_last),
        .op_bad         (op_bad),
        .op_data        (op_data)
    );

endmodule

`default_nettype wire

/* tb_cmd_analyzer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_analyzer;

    typedef struct packed
    {
        logic                check;     // 1 for an expected frame, 0 for a byte
        cmd_pkg::byte_t      value;
        cmd_pkg::cmd_code_t  code;
        cmd_pkg::operand_t   data;
    } step_t;

    logic                CLK;
    logic                RST;
    logic                rx_valid;
    cmd_pkg::byte_t      rx_byte;
    logic                cmd_ack;
    logic                cmd_valid;
    cmd_pkg::cmd_frame_t cmd;

    step_t       steps[$];
    int          n_bytes;
    int          n_frames;
    int          limit;
    int          cycles;
    logic [15:0] lfsr_state;

    cmd_analyzer dut
    (
        .CLK       (CLK),
        .RST       (RST),
        .rx_valid  (rx_valid),
        .rx_byte   (rx_byte),
        .cmd_ack   (cmd_ack),
        .cmd_valid (cmd_valid),
        .cmd       (cmd)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles = cycles + 1;
        if ((limit > 0) && (cycles > limit))
        begin
            $display("timeout after %0d cycles, the DUT never presented a frame", cycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // ********************
    // helpers
    // ********************

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int k = 0; k < n; k++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
        return value;
    endfunction

    function automatic int hex_value(input cmd_pkg::byte_t c);
        if ((c >= "0") && (c <= "9"))
            return int'(c - "0");
        if ((c >= "A") && (c <= "F"))
            return int'(c - "A") + 10;
        if ((c >= "a") && (c <= "f"))
            return int'(c - "a") + 10;
        return -1;
    endfunction

    task automatic add_byte(input cmd_pkg::byte_t b);
        step_t s;
        s       = '0;
        s.value = b;
        steps.push_back(s);
        n_bytes++;
    endtask

    task automatic load_tests();
        int                fd;
        int                ch;
        int                got;
        int                v;
        int                digits;
        logic              done;
        cmd_pkg::byte_t    c;
        cmd_pkg::byte_t    acc;
        logic [2:0]        code_raw;
        cmd_pkg::operand_t data_raw;
        step_t             s;
        done = 1'b0;
        fd   = $fopen("cmd_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open cmd_tests.txt");
            $display("Test failures found");
            $fatal(1);
        end
        else
        begin
            while (!done)
            begin
                ch = $fgetc(fd);
                c  = ch[7:0];
                if (ch < 0)
                begin
                    done = 1'b1;
                end
                else if (c == "#")
                begin
                    while ((ch >= 0) && (ch[7:0] != 8'h0A))
                        ch = $fgetc(fd);            // comment runs to end of line
                end
                else if (c == "B")
                begin
                    acc    = '0;
                    digits = 0;
                    ch     = $fgetc(fd);
                    while ((ch >= 0) && (ch[7:0] != 8'h0A))
                    begin
                        v = hex_value(ch[7:0]);
                        if (v >= 0)
                        begin
                            acc = {acc[3:0], 4'(v)};
                            digits++;
                        end
                        else if (digits > 0)
                        begin
                            add_byte(acc);
                            acc    = '0;
                            digits = 0;
                        end
                        ch = $fgetc(fd);
                    end
                    if (digits > 0)
                        add_byte(acc);
                end
                else if (c == "E")
                begin
                    got = $fscanf(fd, "%h %h", code_raw, data_raw);
                    if (got != 2)
                    begin
                        $display("malformed expected frame line in cmd_tests.txt");
                        $display("Test failures found");
                        $fatal(1);
                    end
                    s       = '0;
                    s.check = 1'b1;
                    s.code  = cmd_pkg::cmd_code_t'(code_raw);
                    s.data  = data_raw;
                    steps.push_back(s);
                    n_frames++;
                end
                else if ((c != " ") && (c != 8'h0A) && (c != 8'h0D) && (c != 8'h09))
                begin
                    $display("unexpected character '%c' in cmd_tests.txt", c);
                    $display("Test failures found");
                    $fatal(1);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic expect_equal(input string name, input cmd_pkg::operand_t actual,
                                input cmd_pkg::operand_t expected);
        assert (actual === expected)
        else
        begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // ********************
    // stimulus and frame checks
    // ********************

    task automatic send_byte(input cmd_pkg::byte_t b);
        int gap;
        gap      = random_bits(2);
        rx_valid = 1'b1;
        rx_byte  = b;
        @(posedge CLK);
        #1;
        rx_valid = 1'b0;
        repeat (gap)                        // idle cycles between bytes
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic take_frame(input cmd_pkg::cmd_code_t code, input cmd_pkg::operand_t data);
        int hold;
        while (cmd_valid !== 1'b1)
        begin
            @(posedge CLK);
            #1;
        end
        expect_equal("cmd.code", 128'(cmd.code), 128'(code));
        expect_equal("cmd.data", cmd.data, data);
        hold    = 1 + random_bits(1);
        cmd_ack = 1'b1;
        repeat (hold)
        begin
            @(posedge CLK);
            #1;
        end
        cmd_ack = 1'b0;
        expect_equal("cmd_valid", 128'(cmd_valid), '0);
    endtask

    initial
    begin
        CLK        = 1'b0;
        RST        = 1'b1;
        rx_valid   = 1'b0;
        rx_byte    = '0;
        cmd_ack    = 1'b0;
        lfsr_state = 16'd3;
        n_bytes    = 0;
        n_frames   = 0;
        cycles     = 0;
        limit      = 0;
        load_tests();
        limit = 5 * n_bytes + 20 * n_frames + 50;
        repeat (5) @(posedge CLK);
        #1;
        RST = 1'b0;
        expect_equal("cmd_valid", 128'(cmd_valid), '0);
        expect_equal("cmd.code", 128'(cmd.code), '0);
        expect_equal("cmd.data", cmd.data, '0);
        foreach (steps[i])
        begin
            if (steps[i].check)
                take_frame(steps[i].code, steps[i].data);
            else
                send_byte(steps[i].value);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* cmd_tests.txt */
# B  bytes in hex, sent in order, one strobe each
# E  expected code and data of the next frame, in hex
# the six commands, bytes after a line end wait for the acknowledge
B 41 44 44 33 36 20 31 32 33 34 35 36 37 38 39 20 41 42 43 44 45 46 30 31 32 0D 0A
B 4D 55 4C
E 1 123456789ABCDEF012
B 4D 55 4C 36 34 20 30 31 32 33 34 35 36 37 38 39 41 42 43 44 45 46 20
B 46 45 44 43 42 41 39 38 37 36 35 34 33 32 31 30 0D 0A
E 2 0123456789ABCDEFFEDCBA9876543210
B 57 52 34 30 5F 38 20 30 30 44 45 41 44 42 45 45 46 20 37 45 0D 0A
E 7 DEADBEEF7E
B 4F 4E 34 30 5F 38 20 31 32 33 34 35 36 37 38 39 30 20 30 31 0D 0A
E 0 123456789001
B 4F 46 46 34 30 5F 38 20 41 42 43 44 45 46 30 31 32 33 20 46 46 0D 0A
E 3 ABCDEF0123FF
B 4C 45 44 34 30 5F 38 20 30 30 30 30 30 30 30 30 30 31 20 38 30 0D 0A
E 4 180
# keyword mismatches
B 4D 55 58
B 36 34 20 31 0D 0A
E 5 0
B 4F 46 58
E 5 0
B 41 44 44 33 37
E 5 0
B 4F 4E 34 20
E 5 0
B 57 52 34 30 5F 38 38
E 5 0
# bad digits
B 57 52 34 30 5F 38 20 31 32 33 34 35 47
E 5 12345
B 41 44 44 33 36 20 31 32 61
E 5 12
# wrong separators
B 4F 46 46 34 30 5F 38 20 30 31 32 33 34 35 36 37 38 39 0D 0A
E 5 123456789
B 4C 45 44 34 30 5F 38 20 46 46 46 46 46 46 46 46 46 46 20 35 41 0D 0D
E 5 FFFFFFFFFF5A
B 4F 4E 34 30 5F 38 20 31 31 31 31 31 31 31 31 31 31 20 32 32 20
E 5 111111111122
# clean line after the errors
B 4F 4E 34 30 5F 38 20 30 30 30 30 30 30 30 30 30 30 20 30 46 0D 0A
E 0 F

/* src.f */
cmd_pkg.sv
keyword_matcher.sv
operand_collector.sv
cmd_sequencer.sv
cmd_analyzer.sv
tb_cmd_analyzer.sv

/* Makefile */
.PHONY: all lint clean

all:
	verilator --binary --assert -f src.f --top-module tb_cmd_analyzer -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall -f src.f --top-module cmd_analyzer

clean:
	rm -rf obj_dir
